// ==== source/mem_pkg.sv ====
package mem_pkg;

    localparam int unsigned data_width    = 32;
    localparam int unsigned mem_bytes     = 4096;
    localparam int unsigned mem_addr_bits = 12;
    localparam int unsigned mem_words     = mem_bytes / 4;

    // access modes, codes 0, 6 and 7 are undefined
    localparam logic [2:0] mode_word   = 3'd1;
    localparam logic [2:0] mode_half   = 3'd2;
    localparam logic [2:0] mode_byte   = 3'd3;
    localparam logic [2:0] mode_half_u = 3'd4;
    localparam logic [2:0] mode_byte_u = 3'd5;

    // result source, code 3 gives zero
    localparam logic [1:0] src_addr = 2'd0;
    localparam logic [1:0] src_load = 2'd1;
    localparam logic [1:0] src_link = 2'd2;

    // store width between control and lane align
    localparam logic [1:0] width_none = 2'd0;
    localparam logic [1:0] width_byte = 2'd1;
    localparam logic [1:0] width_half = 2'd2;
    localparam logic [1:0] width_word = 2'd3;

    typedef struct packed {
        logic                  valid;
        logic                  write_en;
        logic [2:0]            mode;
        logic [1:0]            result_src;
        logic [data_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [data_width-1:0] result;
        logic                  fault;
    } wb_t;

    typedef struct packed {
        logic [mem_addr_bits-3:0] index;
        logic [3:0]               en;   // lane 3 is the msb
        logic [data_width-1:0]    data;
    } lane_wr_t;

    typedef enum logic [2:0] {
        fmt_word,
        fmt_half_s,
        fmt_half_u,
        fmt_byte_s,
        fmt_byte_u,
        fmt_none
    } load_fmt_t;

endpackage

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg
    import mem_pkg::*;
#(
    parameter type payload_t = wb_t
)
(
    input  logic     clk,
    input  logic     reset,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q <= '0;   // drops valid
        end
        else
        begin
            q <= d;
        end
    end

    // strobe must never go X once out of reset, or a result gets lost
    assert property (@(posedge clk) disable iff (reset) !$isunknown(q.valid))
        else $error("stage_reg: valid unknown");

endmodule

// ==== source/mem_access_ctrl.sv ====
`timescale 1ns/1ps

module mem_access_ctrl
    import mem_pkg::*;
(
    input  mem_req_t                 req,
    output logic [mem_addr_bits-3:0] ram_index,
    output logic [1:0]               store_width,
    output logic                     write_go,
    input  lane_wr_t                 lanes_in,
    output lane_wr_t                 lanes_out,
    output load_fmt_t                fmt,
    input  logic [data_width-1:0]    load_value,
    output wb_t                      wb
);

    logic                  fault;
    logic [data_width-1:0] result_sel;

    assign fault     = req.addr >= mem_bytes;
    assign ram_index = req.addr[mem_addr_bits-1:2];   // word base, bits 1:0 dropped

    always_comb
    begin
        case (req.mode)
            mode_word:
            begin
                store_width = width_word;
                fmt         = fmt_word;
            end
            mode_half:
            begin
                store_width = width_half;
                fmt         = fmt_half_s;
            end
            mode_byte:
            begin
                store_width = width_byte;
                fmt         = fmt_byte_s;
            end
            mode_half_u:
            begin
                store_width = width_half;
                fmt         = fmt_half_u;
            end
            mode_byte_u:
            begin
                store_width = width_byte;
                fmt         = fmt_byte_u;
            end
            default:
            begin
                store_width = width_none;   // undefined mode is a no-op
                fmt         = fmt_none;
            end
        endcase
    end

    assign write_go = req.valid && req.write_en && (store_width != width_none) && !fault;

    always_comb
    begin
        lanes_out    = lanes_in;
        lanes_out.en = write_go ? lanes_in.en : 4'b0000;
    end

    always_comb
    begin
        case (req.result_src)
            src_addr: result_sel = req.addr;
            src_load: result_sel = load_value;
            src_link: result_sel = req.addr + 32'd4;
            default:  result_sel = '0;
        endcase
    end

    assign wb.valid  = req.valid;
    assign wb.result = fault ? '0 : result_sel;
    assign wb.fault  = fault;

    // no lane write while faulting, and a write lands on the requested word
    assert final (!((lanes_out.en != 4'b0000) && (fault || lanes_out.index != ram_index)))
        else $error("mem_access_ctrl: lane write during fault or to the wrong word");

endmodule

// ==== source/store_lane_align.sv ====
`timescale 1ns/1ps

module store_lane_align
    import mem_pkg::*;
(
    input  logic [mem_addr_bits-3:0] index,
    input  logic [1:0]               store_width,
    input  logic [data_width-1:0]    wdata,
    output lane_wr_t                 lanes
);

    always_comb
    begin
        lanes.index = index;
        case (store_width)
            width_word:
            begin
                lanes.en   = 4'b1111;
                lanes.data = wdata;
            end
            width_half:
            begin
                lanes.en   = 4'b1100;
                lanes.data = {wdata[15:0], 16'h0000};   // low half onto lanes 3,2
            end
            width_byte:
            begin
                lanes.en   = 4'b1000;
                lanes.data = {wdata[7:0], 24'h000000};
            end
            default:
            begin
                lanes.en   = 4'b0000;
                lanes.data = '0;
            end
        endcase
    end

endmodule

// ==== source/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram
    import mem_pkg::*;
(
    input  logic                     clk,
    input  lane_wr_t                 lanes,
    input  logic [mem_addr_bits-3:0] read_index,
    output logic [data_width-1:0]    read_word
);

    // one byte array per lane, lane 3 holds the lowest byte address
    logic [7:0] lane_mem [4][mem_words];

    initial
    begin
        for (int l = 0; l < 4; l++)
        begin
            for (int w = 0; w < int'(mem_words); w++)
            begin
                lane_mem[l][w] = 8'h00;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int l = 0; l < 4; l++)
        begin
            if (lanes.en[l])
            begin
                lane_mem[l][lanes.index] <= lanes.data[8*l +: 8];
            end
        end
    end

    assign read_word = {lane_mem[3][read_index], lane_mem[2][read_index],
                        lane_mem[1][read_index], lane_mem[0][read_index]};   // big-endian

    // a write must hit a known word inside the array
    assert property (@(posedge clk) (lanes.en != 4'b0000)
                     |-> (!$isunknown(lanes.index) && 32'(lanes.index) < mem_words))
        else $error("byte_ram: write index out of range");

endmodule

// ==== source/load_extend.sv ====
`timescale 1ns/1ps

module load_extend
    import mem_pkg::*;
(
    input  logic [data_width-1:0] read_word,
    input  load_fmt_t             fmt,
    output logic [data_width-1:0] load_value
);

    logic [15:0] half_val;
    logic [7:0]  byte_val;

    assign half_val = read_word[31:16];   // lanes 3,2
    assign byte_val = read_word[31:24];   // lane 3

    always_comb
    begin
        case (fmt)
            fmt_word:
            begin
                load_value = read_word;
            end
            fmt_half_s:
            begin
                load_value = {{16{half_val[15]}}, half_val};
            end
            fmt_half_u:
            begin
                load_value = {16'h0000, half_val};
            end
            fmt_byte_s:
            begin
                load_value = {{24{byte_val[7]}}, byte_val};
            end
            fmt_byte_u:
            begin
                load_value = {24'h000000, byte_val};
            end
            default:
            begin
                load_value = '0;   // fmt_none
            end
        endcase
    end

endmodule

// ==== source/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  logic                  write_en,
    input  logic [2:0]            mode,
    input  logic [1:0]            result_src,
    input  logic [data_width-1:0] addr,
    input  logic [data_width-1:0] wdata,
    output logic                  result_valid,
    output logic [data_width-1:0] result,
    output logic                  fault
);

    mem_req_t                 req_d;
    mem_req_t                 req_q;
    wb_t                      wb_d;
    wb_t                      wb_q;
    lane_wr_t                 lanes_aligned;
    lane_wr_t                 lanes_gated;
    load_fmt_t                fmt;
    logic [mem_addr_bits-3:0] ram_index;
    logic [1:0]               store_width;
    logic [data_width-1:0]    read_word;
    logic [data_width-1:0]    load_value;

    assign req_d = '{
        valid:      req_valid,
        write_en:   write_en,
        mode:       mode,
        result_src: result_src,
        addr:       addr,
        wdata:      wdata
    };

    stage_reg #(.payload_t(mem_req_t)) req_stage (
        .clk   (clk),
        .reset (reset),
        .d     (req_d),
        .q     (req_q)
    );

    mem_access_ctrl ctrl0 (
        .req         (req_q),
        .ram_index   (ram_index),
        .store_width (store_width),
        .write_go    (),              // already folded into lanes_gated
        .lanes_in    (lanes_aligned),
        .lanes_out   (lanes_gated),
        .fmt         (fmt),
        .load_value  (load_value),
        .wb          (wb_d)
    );

    store_lane_align align0 (
        .index       (ram_index),
        .store_width (store_width),
        .wdata       (req_q.wdata),
        .lanes       (lanes_aligned)
    );

    byte_ram ram0 (
        .clk        (clk),
        .lanes      (lanes_gated),
        .read_index (ram_index),
        .read_word  (read_word)
    );

    load_extend ext0 (
        .read_word  (read_word),
        .fmt        (fmt),
        .load_value (load_value)
    );

    stage_reg #(.payload_t(wb_t)) wb_stage (
        .clk   (clk),
        .reset (reset),
        .d     (wb_d),
        .q     (wb_q)
    );

    assign result_valid = wb_q.valid;
    assign result       = wb_q.result;
    assign fault        = wb_q.fault;

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock
#(
    parameter realtime half_period = 20ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;   // 40 ns period
    end

endmodule

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb
    import mem_pkg::*;
;

    typedef struct packed {
        logic [31:0] result;
        logic        fault;
        logic [31:0] cycle;   // cycle of the strobe
    } exp_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    logic        write_en;
    logic [2:0]  mode;
    logic [1:0]  result_src;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        result_valid;
    logic [31:0] result;
    logic        fault;

    logic [7:0]  model_mem [mem_bytes];   // big-endian byte image
    exp_t        exp_q [$];
    exp_t        head;
    logic [31:0] rng_state = 32'h4a3e;
    logic [31:0] cycle_count = 0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          checks = 0;
    int          tests_run = 0;

    tb_clock clock0 (.clk(clk));

    mem_stage_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .write_en     (write_en),
        .mode         (mode),
        .result_src   (result_src),
        .addr         (addr),
        .wdata        (wdata),
        .result_valid (result_valid),
        .result       (result),
        .fault        (fault)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] model_result(input logic [2:0] md, input logic [1:0] src,
                                                 input logic [31:0] a);
        logic [11:0] base;
        logic [15:0] half;
        logic [7:0]  lsb_byte;
        logic [31:0] load;
        base     = {a[11:2], 2'b00};
        half     = {model_mem[base], model_mem[base + 12'd1]};
        lsb_byte = model_mem[base];   // lowest address is the msb
        case (md)
            mode_word:   load = {half, model_mem[base + 12'd2], model_mem[base + 12'd3]};
            mode_half:   load = {{16{half[15]}}, half};
            mode_byte:   load = {{24{lsb_byte[7]}}, lsb_byte};
            mode_half_u: load = {16'h0000, half};
            mode_byte_u: load = {24'h000000, lsb_byte};
            default:     load = 32'h0;
        endcase
        if (a >= mem_bytes)
            return 32'h0;
        case (src)
            src_addr: return a;
            src_load: return load;
            src_link: return a + 32'd4;
            default:  return 32'h0;
        endcase
    endfunction

    task automatic model_store(input logic we, input logic [2:0] md, input logic [31:0] a,
                               input logic [31:0] wd);
        logic [11:0] base;
        base = {a[11:2], 2'b00};
        if (we && a < mem_bytes)
        begin
            if (md == mode_word)
            begin
                model_mem[base]          = wd[31:24];
                model_mem[base + 12'd1] = wd[23:16];
                model_mem[base + 12'd2] = wd[15:8];
                model_mem[base + 12'd3] = wd[7:0];
            end
            else if (md == mode_half || md == mode_half_u)
            begin
                model_mem[base]          = wd[15:8];
                model_mem[base + 12'd1] = wd[7:0];
            end
            else if (md == mode_byte || md == mode_byte_u)
            begin
                model_mem[base] = wd[7:0];
            end
        end
    endtask

    task automatic send_request(input logic we, input logic [2:0] md, input logic [1:0] src,
                                input logic [31:0] a, input logic [31:0] wd);
        exp_t e;
        @(posedge clk);
        #2;
        req_valid  = 1'b1;
        write_en   = we;
        mode       = md;
        result_src = src;
        addr       = a;
        wdata      = wd;
        e.result   = model_result(md, src, a);   // load sees the old data
        e.fault    = (a >= mem_bytes);
        e.cycle    = cycle_count;
        exp_q.push_back(e);
        model_store(we, md, a, wd);
    endtask

    task automatic stop_requests();
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        write_en  = 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout: %0d results never arrived on result_valid", exp_q.size());
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic report_test(input string name);
        stop_requests();
        wait_results();
        tests_run++;
        $display("test %0d %s done, %0d errors", tests_run, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // compare every result strobe with the oldest outstanding request
    always @(negedge clk)
    begin
        if (!reset && result_valid)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("** Error at %0t: result strobe without a request", $time);
                errors++;
            end
            if (exp_q.size() != 0)
            begin
                head = exp_q.pop_front();
                checks++;
                assert (result === head.result)
                else
                begin
                    $display("** Error at %0t: result = %h, expected %h", $time, result,
                             head.result);
                    errors++;
                end
                assert (fault === head.fault)
                else
                begin
                    $display("** Error at %0t: fault = %b, expected %b", $time, fault,
                             head.fault);
                    errors++;
                end
                assert (cycle_count - head.cycle == 2)
                else
                begin
                    $display("result at %0t came %0d cycles after its strobe instead of 2",
                             $time, cycle_count - head.cycle);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        logic [31:0] a;
        reset      = 1'b1;
        req_valid  = 1'b0;
        write_en   = 1'b0;
        mode       = 3'd0;
        result_src = 2'd0;
        addr       = 32'h0;
        wdata      = 32'h0;
        for (int i = 0; i < int'(mem_bytes); i++)
            model_mem[i] = 8'h00;   // ram starts cleared
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (10)
        begin
            @(negedge clk);
            assert (result_valid === 1'b0)
            else
            begin
                $display("** Error at %0t: result_valid = %b, expected 0", $time, result_valid);
                errors++;
            end
        end
        report_test("idle after reset");

        for (int i = 0; i < 20; i++)
        begin
            a = next_rand() & 32'hfff;
            send_request(1'b1, mode_word, src_load, a, next_rand());
            send_request(1'b0, mode_word, src_load, a, 32'h0);
        end
        report_test("word store and load");

        for (int i = 0; i < 12; i++)
        begin
            a = next_rand() & 32'hfff;
            send_request(1'b1, mode_word, src_addr, a, next_rand());
            send_request(1'b1, (i % 2) ? mode_half_u : mode_half, src_load, a, next_rand());
            for (logic [2:0] m = mode_word; m <= mode_byte_u; m++)
                send_request(1'b0, m, src_load, a, 32'h0);
            send_request(1'b1, (i % 2) ? mode_byte : mode_byte_u, src_load, a, next_rand());
            for (logic [2:0] m = mode_word; m <= mode_byte_u; m++)
                send_request(1'b0, m, src_load, a, 32'h0);
        end
        report_test("half and byte access");

        a = next_rand() & 32'hffc;
        send_request(1'b1, mode_word, src_link, a, next_rand());
        send_request(1'b0, mode_byte, src_load, a | 32'd3, 32'h0);   // same word
        for (int i = 0; i < 300; i++)
            send_request(1'(next_rand()), 3'(next_rand()), 2'(next_rand() % 3),
                         next_rand() & 32'hfff, next_rand());
        report_test("back to back random");

        for (int i = 0; i < 30; i++)
            send_request(1'b1, 3'(32'd1 + next_rand() % 5), 2'(next_rand()),
                         next_rand() | 32'h1000, next_rand());
        for (int w = 0; w < int'(mem_words); w++)
            send_request(1'b0, mode_word, src_load, w * 4, 32'h0);   // full readback
        report_test("out of range fault");

        for (int i = 0; i < 20; i++)
        begin
            a = next_rand() & 32'hfff;
            send_request(1'b1, (i % 3 == 0) ? 3'd0 : 3'(6 + i % 2), src_load, a, next_rand());
            send_request(1'b0, mode_word, src_load, a, 32'h0);
        end
        report_test("undefined modes");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== project.f ====
source/mem_pkg.sv
source/stage_reg.sv
source/mem_access_ctrl.sv
source/store_lane_align.sv
source/byte_ram.sv
source/load_extend.sv
source/mem_stage_top.sv
verification/tb_clock.sv
verification/mem_stage_tb.sv

// ==== Makefile ====
TOP = mem_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
